// ==== project.f ====
+incdir+tests
rtl/pet_pkg.sv
rtl/bus_timing.sv
rtl/address_decoder.sv
rtl/ram_bridge.sv
rtl/register_file.sv
rtl/pet_bus.sv
tests/pet_bus_tb.sv

// ==== rtl/address_decoder.sv ====
`timescale 1ns/1ps

module address_decoder (
    input  logic                               cpu_be_i,
    input  logic [pet_pkg::CPU_ADDR_WIDTH-1:0] addr_i,

    output logic ram_en_o,      // SRAM backs RAM, VRAM and ROM
    output logic io_en_o,       // Whole I/O page
    output logic pia1_en_o,
    output logic pia2_en_o,
    output logic via_en_o,
    output logic is_vram_o,
    output logic is_rom_o
);
    import pet_pkg::*;

    logic in_io_page;

    always_comb begin
        // E800h to EFFFh
        in_io_page = (addr_i[15:11] == IO_PAGE[7:3]);

        is_vram_o = (addr_i >= VRAM_BASE) && (addr_i <= VRAM_END);
        is_rom_o  = (addr_i >= ROM_BASE) && !in_io_page;

        ram_en_o = cpu_be_i && !in_io_page;
        io_en_o  = cpu_be_i && in_io_page;

        // Chips are picked by A4, A5 and A6 within the page
        pia1_en_o = io_en_o && (addr_i[6:4] == PIA1_BASE[6:4]);
        pia2_en_o = io_en_o && (addr_i[6:4] == PIA2_BASE[6:4]);
        via_en_o  = io_en_o && (addr_i[6:4] == VIA_BASE[6:4]);
    end

    always_comb begin
        assert final ($onehot0({pia1_en_o, pia2_en_o, via_en_o}))
            else $error("Several I/O chips selected at %h", addr_i);
    end

endmodule

// ==== rtl/bus_timing.sv ====
`timescale 1ns/1ps

module bus_timing (
    input  logic sys_clock_i,       // 64 MHz
    input  logic sys_reset_ni,

    output logic cpu_be_o,          // CPU owns the bus
    output logic cpu_clock_o,       // PHI2, 1 MHz
    output logic cpu_wr_strobe_o,   // One clock, late in PHI2
    output logic ram_slot_o         // Host may start an SRAM access
);
    import pet_pkg::*;

    logic [$clog2(TIMING_PERIOD)-1:0] count;
    logic [$clog2(TIMING_PERIOD)-1:0] count_next;

    assign count_next = (count == TIMING_PERIOD - 1) ? '0 : count + 1'b1;

    // Outputs are decoded from the next count and registered,
    // so each one lines up with the count it belongs to
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            count           <= '0;
            cpu_be_o        <= 1'b0;
            cpu_clock_o     <= 1'b0;
            cpu_wr_strobe_o <= 1'b0;
            ram_slot_o      <= 1'b1;    // Count 0 is inside the slot
        end else begin
            count           <= count_next;
            cpu_be_o        <= (count_next > WB_WINDOW_END);
            cpu_clock_o     <= (count_next >= PHI2_START);
            cpu_wr_strobe_o <= (count_next == WR_STROBE_COUNT);
            ram_slot_o      <= (count_next <= RAM_SLOT_END);
        end
    end

    // Host accesses must start and finish before the CPU takes the bus
    slot_outside_cpu_phase: assert property (
        @(posedge sys_clock_i) disable iff (!sys_reset_ni)
        ram_slot_o |-> !cpu_be_o
    ) else $error("RAM slot overlaps the CPU phase");

    // The write strobe lands in PHI2 while the CPU still drives the bus
    strobe_in_phi2: assert property (
        @(posedge sys_clock_i) disable iff (!sys_reset_ni)
        cpu_wr_strobe_o |-> cpu_clock_o && cpu_be_o ##1 cpu_clock_o
    ) else $error("CPU write strobe outside of PHI2");

endmodule

// ==== rtl/pet_bus.sv ====
`timescale 1ns/1ps

module pet_bus (
    input  logic                               sys_clock_i,
    input  logic                               sys_reset_ni,

    // Wishbone host port
    input  logic [pet_pkg::WB_ADDR_WIDTH-1:0]  wb_addr_i,
    input  logic [pet_pkg::DATA_WIDTH-1:0]     wb_data_i,
    output logic [pet_pkg::DATA_WIDTH-1:0]     wb_data_o,
    input  logic                               wb_we_i,
    input  logic                               wb_cycle_i,
    input  logic                               wb_strobe_i,
    output logic                               wb_stall_o,
    output logic                               wb_ack_o,

    // CPU
    input  logic [pet_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [pet_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                               cpu_we_i,
    output logic [pet_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_o,
    output logic                               cpu_addr_oe_o,
    output logic [pet_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                               cpu_data_oe_o,
    output logic                               cpu_be_o,
    output logic                               cpu_clock_o,
    output logic                               cpu_reset_o,
    output logic                               cpu_ready_o,

    // SRAM and I/O chips
    output logic                               ram_addr_a10_o,
    output logic                               ram_addr_a11_o,
    output logic                               ram_addr_a15_o,
    output logic                               ram_addr_a16_o,
    output logic                               ram_oe_o,
    output logic                               ram_we_o,
    output logic                               io_oe_o,
    output logic                               pia1_cs_o,
    output logic                               pia2_cs_o,
    output logic                               via_cs_o
);
    import pet_pkg::*;

    logic cpu_wr_strobe;
    logic ram_slot;

    logic ram_en;
    logic io_en;
    logic pia1_en;
    logic pia2_en;
    logic via_en;
    logic is_vram;
    logic is_rom;

    logic [DATA_WIDTH-1:0]     ram_wb_data;
    logic                      ram_wb_stall;
    logic                      ram_wb_ack;
    logic [RAM_ADDR_WIDTH-1:0] ram_ctl_addr;
    logic                      ram_ctl_oe;
    logic                      ram_ctl_we;
    logic [DATA_WIDTH-1:0]     ram_ctl_data;   // Host write data toward SRAM
    logic                      ram_ctl_doe;

    logic [DATA_WIDTH-1:0] reg_wb_data;
    logic                  reg_wb_ack;
    logic                  col_80_mode;
    logic [11:10]          vram_mask;

    logic cpu_rd_en;
    logic cpu_wr_en;
    logic a10_keep;
    logic a11_keep;

    bus_timing i_bus_timing (
        .sys_clock_i     (sys_clock_i),
        .sys_reset_ni    (sys_reset_ni),
        .cpu_be_o        (cpu_be_o),
        .cpu_clock_o     (cpu_clock_o),
        .cpu_wr_strobe_o (cpu_wr_strobe),
        .ram_slot_o      (ram_slot)
    );

    address_decoder i_address_decoder (
        .cpu_be_i  (cpu_be_o),
        .addr_i    (cpu_addr_i),
        .ram_en_o  (ram_en),
        .io_en_o   (io_en),
        .pia1_en_o (pia1_en),
        .pia2_en_o (pia2_en),
        .via_en_o  (via_en),
        .is_vram_o (is_vram),
        .is_rom_o  (is_rom)
    );

    ram_bridge i_ram_bridge (
        .sys_clock_i   (sys_clock_i),
        .sys_reset_ni  (sys_reset_ni),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .wb_data_o     (ram_wb_data),
        .wb_we_i       (wb_we_i),
        .wb_cycle_i    (wb_cycle_i),
        .wb_strobe_i   (wb_strobe_i),
        .wb_stall_o    (ram_wb_stall),
        .wb_ack_o      (ram_wb_ack),
        .ram_slot_i    (ram_slot),
        .cpu_be_i      (cpu_be_o),
        .ram_addr_o    (ram_ctl_addr),
        .ram_oe_o      (ram_ctl_oe),
        .ram_we_o      (ram_ctl_we),
        .ram_data_i    (cpu_data_i),    // SRAM shares the CPU data bus
        .ram_data_o    (ram_ctl_data),
        .ram_data_oe_o (ram_ctl_doe)
    );

    register_file i_register_file (
        .sys_clock_i   (sys_clock_i),
        .sys_reset_ni  (sys_reset_ni),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .wb_data_o     (reg_wb_data),
        .wb_we_i       (wb_we_i),
        .wb_cycle_i    (wb_cycle_i),
        .wb_strobe_i   (wb_strobe_i),
        .wb_ack_o      (reg_wb_ack),
        .cpu_reset_o   (cpu_reset_o),
        .cpu_ready_o   (cpu_ready_o),
        .col_80_mode_o (col_80_mode),
        .vram_mask_o   (vram_mask)
    );

    // Idle peripherals drive zero data
    assign wb_data_o  = ram_wb_data | reg_wb_data;
    assign wb_stall_o = ram_wb_stall;
    assign wb_ack_o   = ram_wb_ack | reg_wb_ack;

    always_comb begin
        if (ram_ctl_doe) begin
            cpu_data_o    = ram_ctl_data;
            cpu_data_oe_o = 1'b1;
        end else begin
            cpu_data_o    = '0;
            cpu_data_oe_o = 1'b0;
        end
    end

    assign cpu_rd_en = cpu_be_o && !cpu_we_i;
    assign cpu_wr_en = cpu_be_o && cpu_we_i && cpu_clock_o;

    assign ram_oe_o = (cpu_rd_en && ram_en) || ram_ctl_oe;
    assign ram_we_o = (cpu_wr_en && ram_en && !is_rom) || ram_ctl_we;     // ROM stays intact

    assign io_oe_o   = io_en && cpu_be_o;
    assign pia1_cs_o = pia1_en && cpu_be_o;
    assign pia2_cs_o = pia2_en && cpu_be_o;
    assign via_cs_o  = via_en && cpu_be_o;

    assign cpu_addr_oe_o = !cpu_be_o;
    assign cpu_addr_o    = ram_ctl_addr[CPU_ADDR_WIDTH-1:0];

    // 40 column text only needs 1 KiB of VRAM, so mirror it unless unmasked
    assign a10_keep = !is_vram || vram_mask[10] || col_80_mode;
    assign a11_keep = !is_vram || vram_mask[11];

    assign ram_addr_a10_o = cpu_be_o ? (cpu_addr_i[10] && a10_keep) : ram_ctl_addr[10];
    assign ram_addr_a11_o = cpu_be_o ? (cpu_addr_i[11] && a11_keep) : ram_ctl_addr[11];
    assign ram_addr_a15_o = cpu_be_o ? cpu_addr_i[15] : ram_ctl_addr[15];
    assign ram_addr_a16_o = cpu_be_o ? 1'b0 : ram_ctl_addr[16];

    io_excludes_ram: assert property (
        @(posedge sys_clock_i) disable iff (!sys_reset_ni)
        io_oe_o |-> !ram_oe_o && !ram_we_o
    ) else $error("I/O and SRAM enabled together");

    io_needs_cpu: assert property (
        @(posedge sys_clock_i) disable iff (!sys_reset_ni)
        io_oe_o |-> cpu_be_o
    ) else $error("I/O enabled without the CPU on the bus");

    // Bridge must be idle when a CPU write completes
    bridge_idle_at_strobe: assert property (
        @(posedge sys_clock_i) disable iff (!sys_reset_ni)
        cpu_wr_strobe |-> !ram_ctl_oe && !ram_ctl_we && !ram_ctl_doe
    ) else $error("SRAM bridge busy at the CPU write strobe");

endmodule

// ==== rtl/pet_pkg.sv ====
package pet_pkg;

    // Bus widths
    localparam int CPU_ADDR_WIDTH = 16;
    localparam int DATA_WIDTH     = 8;
    localparam int RAM_ADDR_WIDTH = 17;     // 128 KiB SRAM
    localparam int WB_ADDR_WIDTH  = 18;     // Space bit + SRAM address

    // Positions within one CPU period of 64 system clocks
    localparam int TIMING_PERIOD   = 64;
    localparam int WB_WINDOW_END   = 15;    // Bus released to the host up to here
    localparam int RAM_SLOT_END    = 11;    // Last start leaving room for 4 cycles
    localparam int PHI2_START      = 32;
    localparam int WR_STROBE_COUNT = 62;

    // Register indices
    localparam logic [3:0] REG_CONTROL = 4'd0;
    localparam logic [3:0] REG_VIDEO   = 4'd1;

    // PET memory map
    localparam logic [15:0] VRAM_BASE = 16'h8000;
    localparam logic [15:0] VRAM_END  = 16'h8fff;
    localparam logic [15:0] ROM_BASE  = 16'h9000;
    localparam logic [7:0]  IO_PAGE   = 8'he8;
    localparam logic [15:0] PIA1_BASE = 16'he810;
    localparam logic [15:0] PIA2_BASE = 16'he820;
    localparam logic [15:0] VIA_BASE  = 16'he840;

    // The same host address word, seen by the SRAM bridge or the register file
    typedef union packed {
        struct packed {
            logic                      space;   // 0 for SRAM
            logic [RAM_ADDR_WIDTH-1:0] addr;
        } ram;
        struct packed {
            logic        space;                 // 1 for registers
            logic [12:0] reserved;
            logic [3:0]  index;
        } regs;
    } wb_addr_t;

endpackage

// ==== rtl/ram_bridge.sv ====
`timescale 1ns/1ps

module ram_bridge (
    input  logic                               sys_clock_i,
    input  logic                               sys_reset_ni,

    // Wishbone peripheral
    input  pet_pkg::wb_addr_t                  wb_addr_i,
    input  logic [pet_pkg::DATA_WIDTH-1:0]     wb_data_i,
    output logic [pet_pkg::DATA_WIDTH-1:0]     wb_data_o,
    input  logic                               wb_we_i,
    input  logic                               wb_cycle_i,
    input  logic                               wb_strobe_i,
    output logic                               wb_stall_o,
    output logic                               wb_ack_o,

    // From bus_timing
    input  logic                               ram_slot_i,
    input  logic                               cpu_be_i,

    // SRAM side
    output logic [pet_pkg::RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                               ram_oe_o,
    output logic                               ram_we_o,
    input  logic [pet_pkg::DATA_WIDTH-1:0]     ram_data_i,
    output logic [pet_pkg::DATA_WIDTH-1:0]     ram_data_o,
    output logic                               ram_data_oe_o
);
    import pet_pkg::*;

    logic [1:0]            step;        // 0 idle, 1 to 3 drive the SRAM
    logic                  selected;
    logic                  busy;
    logic                  accept;
    logic [DATA_WIDTH-1:0] read_data;

    assign selected   = wb_cycle_i && wb_strobe_i && !wb_addr_i.ram.space;
    assign busy       = (step != 2'd0);
    assign wb_stall_o = selected && (!ram_slot_i || busy);     // Wait for next slot
    assign accept     = selected && !wb_stall_o;

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            ram_addr_o <= wb_addr_i.ram.addr;
            ram_data_o <= wb_data_i;
        end

        // Last cycle of the access, SRAM output has settled
        if (step == 2'd3) begin
            read_data <= ram_oe_o ? ram_data_i : '0;
        end
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            step          <= 2'd0;
            ram_oe_o      <= 1'b0;
            ram_we_o      <= 1'b0;
            ram_data_oe_o <= 1'b0;
            wb_ack_o      <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;

            case (step)
                2'd0: begin
                    if (accept) begin
                        step          <= 2'd1;
                        ram_oe_o      <= !wb_we_i;
                        ram_we_o      <= wb_we_i;
                        ram_data_oe_o <= wb_we_i;
                    end
                end
                2'd1: step <= 2'd2;
                2'd2: begin
                    step     <= 2'd3;
                    ram_we_o <= 1'b0;   // Data held one cycle past WE
                end
                default: begin
                    step          <= 2'd0;
                    ram_oe_o      <= 1'b0;
                    ram_data_oe_o <= 1'b0;
                    wb_ack_o      <= 1'b1;
                end
            endcase
        end
    end

    assign wb_data_o = wb_ack_o ? read_data : '0;

    // A request started in the slot must be over before the CPU phase
    quiet_in_cpu_phase: assert property (
        @(posedge sys_clock_i) disable iff (!sys_reset_ni)
        cpu_be_i |-> !(ram_oe_o || ram_we_o || wb_ack_o)
    ) else $error("SRAM bridge active while the CPU owns the bus");

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                           sys_clock_i,
    input  logic                           sys_reset_ni,

    // Wishbone peripheral, never stalls
    input  pet_pkg::wb_addr_t              wb_addr_i,
    input  logic [pet_pkg::DATA_WIDTH-1:0] wb_data_i,
    output logic [pet_pkg::DATA_WIDTH-1:0] wb_data_o,
    input  logic                           wb_we_i,
    input  logic                           wb_cycle_i,
    input  logic                           wb_strobe_i,
    output logic                           wb_ack_o,

    output logic                           cpu_reset_o,
    output logic                           cpu_ready_o,
    output logic                           col_80_mode_o,
    output logic [11:10]                   vram_mask_o      // Keeps A11/A10 for VRAM
);
    import pet_pkg::*;

    logic                  accept;
    logic [DATA_WIDTH-1:0] read_value;
    logic [DATA_WIDTH-1:0] read_data;

    assign accept = wb_cycle_i && wb_strobe_i && wb_addr_i.regs.space;

    always_comb begin
        read_value = '0;
        case (wb_addr_i.regs.index)
            REG_CONTROL: read_value[1:0] = {cpu_ready_o, cpu_reset_o};
            REG_VIDEO:   read_value[2:0] = {vram_mask_o, col_80_mode_o};
            default:     read_value = '0;   // Unknown index reads zero
        endcase
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            read_data <= wb_we_i ? '0 : read_value;
        end
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            wb_ack_o      <= 1'b0;
            cpu_reset_o   <= 1'b1;      // CPU held until the MCU has loaded ROMs
            cpu_ready_o   <= 1'b0;
            col_80_mode_o <= 1'b0;
            vram_mask_o   <= 2'b11;
        end else begin
            wb_ack_o <= accept;

            if (accept && wb_we_i) begin
                case (wb_addr_i.regs.index)
                    REG_CONTROL: begin
                        cpu_reset_o <= wb_data_i[0];
                        cpu_ready_o <= wb_data_i[1];
                    end
                    REG_VIDEO: begin
                        col_80_mode_o <= wb_data_i[0];
                        vram_mask_o   <= wb_data_i[2:1];
                    end
                    default: ;  // Write dropped, still acked
                endcase
            end
        end
    end

    assign wb_data_o = wb_ack_o ? read_data : '0;

endmodule

// ==== tests/pet_bus_tb_table.svh ====
// Columns: name, kind, address, write, data, expected
// CPU expected bits: ram_oe ram_we io_oe pia1 pia2 via a11 a10, register reads: data
entries.push_back('{"cpu_zero_page_rd",    ACC_CPU, 18'h00000, 1'b0, 8'h00, 8'b1000_0000});
entries.push_back('{"cpu_low_wr",          ACC_CPU, 18'h00c00, 1'b1, 8'h5a, 8'b0100_0011});
entries.push_back('{"cpu_vram_rd",         ACC_CPU, 18'h08c00, 1'b0, 8'h00, 8'b1000_0011});
entries.push_back('{"cpu_vram_wr",         ACC_CPU, 18'h08400, 1'b1, 8'ha5, 8'b0100_0001});
entries.push_back('{"cpu_vram_top_rd",     ACC_CPU, 18'h08fff, 1'b0, 8'h00, 8'b1000_0011});
entries.push_back('{"cpu_rom_rd",          ACC_CPU, 18'h0c000, 1'b0, 8'h00, 8'b1000_0000});
entries.push_back('{"cpu_rom_wr",          ACC_CPU, 18'h0f800, 1'b1, 8'h3c, 8'b0000_0010});
entries.push_back('{"cpu_rom_low_wr",      ACC_CPU, 18'h09c00, 1'b1, 8'hc3, 8'b0000_0011});
entries.push_back('{"cpu_below_io_rd",     ACC_CPU, 18'h0e7ff, 1'b0, 8'h00, 8'b1000_0001});
entries.push_back('{"cpu_pia1_rd",         ACC_CPU, 18'h0e810, 1'b0, 8'h00, 8'b0011_0010});
entries.push_back('{"cpu_pia2_wr",         ACC_CPU, 18'h0e820, 1'b1, 8'h77, 8'b0010_1010});
entries.push_back('{"cpu_via_rd",          ACC_CPU, 18'h0e840, 1'b0, 8'h00, 8'b0010_0110});
entries.push_back('{"cpu_io_gap_rd",       ACC_CPU, 18'h0e800, 1'b0, 8'h00, 8'b0010_0010});
entries.push_back('{"cpu_pia1_mirror_rd",  ACC_CPU, 18'h0e91a, 1'b0, 8'h00, 8'b0011_0010});
entries.push_back('{"cpu_io_top_rd",       ACC_CPU, 18'h0eff0, 1'b0, 8'h00, 8'b0010_0011});
entries.push_back('{"reg_video_reset_rd",  ACC_REG, 18'h20001, 1'b0, 8'h00, 8'h06});
entries.push_back('{"reg_video_wr_00",     ACC_REG, 18'h20001, 1'b1, 8'h00, 8'h00});
entries.push_back('{"reg_video_rd_00",     ACC_REG, 18'h20001, 1'b0, 8'h00, 8'h00});
entries.push_back('{"cpu_vram_mask00_rd",  ACC_CPU, 18'h08c00, 1'b0, 8'h00, 8'b1000_0000});
entries.push_back('{"cpu_vram_mask00_wr",  ACC_CPU, 18'h08400, 1'b1, 8'h11, 8'b0100_0000});
entries.push_back('{"cpu_low_unmasked_rd", ACC_CPU, 18'h00c00, 1'b0, 8'h00, 8'b1000_0011});
entries.push_back('{"cpu_rom_unmasked_rd", ACC_CPU, 18'h09c00, 1'b0, 8'h00, 8'b1000_0011});
entries.push_back('{"reg_video_wr_a10",    ACC_REG, 18'h20001, 1'b1, 8'h02, 8'h00});
entries.push_back('{"reg_video_rd_a10",    ACC_REG, 18'h20001, 1'b0, 8'h00, 8'h02});
entries.push_back('{"cpu_vram_a10_rd",     ACC_CPU, 18'h08c00, 1'b0, 8'h00, 8'b1000_0001});
entries.push_back('{"reg_video_wr_col80",  ACC_REG, 18'h20001, 1'b1, 8'hf9, 8'h00});
entries.push_back('{"reg_video_rd_col80",  ACC_REG, 18'h20001, 1'b0, 8'h00, 8'h01});
entries.push_back('{"cpu_vram_col80_rd",   ACC_CPU, 18'h08c00, 1'b0, 8'h00, 8'b1000_0001});
entries.push_back('{"reg_video_wr_a11",    ACC_REG, 18'h20001, 1'b1, 8'h04, 8'h00});
entries.push_back('{"cpu_vram_a11_rd",     ACC_CPU, 18'h08c00, 1'b0, 8'h00, 8'b1000_0010});
entries.push_back('{"reg_unknown_wr",      ACC_REG, 18'h20005, 1'b1, 8'hff, 8'h00});
entries.push_back('{"reg_unknown_rd",      ACC_REG, 18'h20005, 1'b0, 8'h00, 8'h00});
entries.push_back('{"ram_pair_low",        ACC_RAM, 18'h00000, 1'b0, 8'h00, 8'h00});
entries.push_back('{"ram_pair_high",       ACC_RAM, 18'h10000, 1'b0, 8'h00, 8'h00});
entries.push_back('{"ram_pair_low_2",      ACC_RAM, 18'h00000, 1'b0, 8'h00, 8'h00});
entries.push_back('{"ram_pair_high_2",     ACC_RAM, 18'h10000, 1'b0, 8'h00, 8'h00});
entries.push_back('{"reg_control_reset_rd", ACC_REG, 18'h20000, 1'b0, 8'h00, 8'h01});
entries.push_back('{"reg_control_wr",      ACC_REG, 18'h20000, 1'b1, 8'h02, 8'h00});
entries.push_back('{"reg_control_rd",      ACC_REG, 18'h20000, 1'b0, 8'h00, 8'h02});

// ==== tests/pet_bus_tb.sv ====
`timescale 1ns/1ps

module pet_bus_tb;
    import pet_pkg::*;

    typedef enum int {ACC_CPU, ACC_REG, ACC_RAM} kind_e;

    typedef struct {
        string       name;
        kind_e       kind;
        logic [17:0] addr;
        logic        we;
        logic [7:0]  data;
        logic [7:0]  expected;
    } entry_t;

    logic                      sys_clock;
    logic                      sys_reset_n;
    logic [WB_ADDR_WIDTH-1:0]  wb_addr;
    logic [DATA_WIDTH-1:0]     wb_wdata;
    logic [DATA_WIDTH-1:0]     wb_data_o;
    logic                      wb_we;
    logic                      wb_cycle;
    logic                      wb_strobe;
    logic                      wb_stall_o;
    logic                      wb_ack_o;
    logic [CPU_ADDR_WIDTH-1:0] cpu_addr;
    logic [DATA_WIDTH-1:0]     cpu_data;
    logic [DATA_WIDTH-1:0]     data_bus;        // Shared CPU/SRAM data bus
    logic                      cpu_we;
    logic [CPU_ADDR_WIDTH-1:0] cpu_addr_o;
    logic                      cpu_addr_oe_o;
    logic [DATA_WIDTH-1:0]     cpu_data_o;
    logic                      cpu_data_oe_o;
    logic                      cpu_be_o;
    logic                      cpu_clock_o;
    logic                      cpu_reset_o;
    logic                      cpu_ready_o;
    logic                      ram_addr_a10_o;
    logic                      ram_addr_a11_o;
    logic                      ram_addr_a15_o;
    logic                      ram_addr_a16_o;
    logic                      ram_oe_o;
    logic                      ram_we_o;
    logic                      io_oe_o;
    logic                      pia1_cs_o;
    logic                      pia2_cs_o;
    logic                      via_cs_o;

    logic [DATA_WIDTH-1:0]     sram [0:2**RAM_ADDR_WIDTH-1];
    logic [RAM_ADDR_WIDTH-1:0] sram_addr;

    entry_t entries[$];
    int     errors;
    int     cycles;
    int     cycle_limit;
    int     requests;
    int     acks;
    int     periods;
    int     low_run;
    int     phase;
    bit     seen_be;
    bit     phase_valid;
    logic   prev_be;
    logic   prev_clock;

    pet_bus i_pet_bus (
        .sys_clock_i    (sys_clock),
        .sys_reset_ni   (sys_reset_n),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_wdata),
        .wb_data_o      (wb_data_o),
        .wb_we_i        (wb_we),
        .wb_cycle_i     (wb_cycle),
        .wb_strobe_i    (wb_strobe),
        .wb_stall_o     (wb_stall_o),
        .wb_ack_o       (wb_ack_o),
        .cpu_addr_i     (cpu_addr),
        .cpu_data_i     (data_bus),
        .cpu_we_i       (cpu_we),
        .cpu_addr_o     (cpu_addr_o),
        .cpu_addr_oe_o  (cpu_addr_oe_o),
        .cpu_data_o     (cpu_data_o),
        .cpu_data_oe_o  (cpu_data_oe_o),
        .cpu_be_o       (cpu_be_o),
        .cpu_clock_o    (cpu_clock_o),
        .cpu_reset_o    (cpu_reset_o),
        .cpu_ready_o    (cpu_ready_o),
        .ram_addr_a10_o (ram_addr_a10_o),
        .ram_addr_a11_o (ram_addr_a11_o),
        .ram_addr_a15_o (ram_addr_a15_o),
        .ram_addr_a16_o (ram_addr_a16_o),
        .ram_oe_o       (ram_oe_o),
        .ram_we_o       (ram_we_o),
        .io_oe_o        (io_oe_o),
        .pia1_cs_o      (pia1_cs_o),
        .pia2_cs_o      (pia2_cs_o),
        .via_cs_o       (via_cs_o)
    );

    initial begin
        sys_clock = 1'b0;
        forever #4 sys_clock = ~sys_clock;
    end

    // SRAM model, host side only
    assign sram_addr = {ram_addr_a16_o, cpu_addr_o};
    assign data_bus  = (ram_oe_o && !cpu_be_o) ? sram[sram_addr] : cpu_data;

    always @(negedge sys_clock) begin
        if (ram_we_o && cpu_data_oe_o && !cpu_be_o) sram[sram_addr] <= cpu_data_o;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_value,
                                   input logic [31:0] act_value);
        errors++;
        $display("[ERROR] %s: expected %h, actual %h", name, exp_value, act_value);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure: %s", what);
    endtask

    task automatic load_table;
        `include "pet_bus_tb_table.svh"
    endtask

    // Bus period shape and quiet window
    always @(negedge sys_clock) begin
        if (sys_reset_n) begin
            if (!cpu_be_o && (io_oe_o || pia1_cs_o || pia2_cs_o || via_cs_o))
                report_failure("I/O select active while the host owns the bus");
            if (!cpu_be_o && ram_we_o && !cpu_data_oe_o)
                report_failure("CPU write reached the SRAM outside the CPU phase");
            if (cpu_addr_oe_o !== !cpu_be_o)
                report_failure("CPU address output enable does not follow the bus enable");
            if (!cpu_be_o) begin
                if (prev_be) begin
                    if (phase_valid && phase != 64) report_mismatch("bus_period", 64, phase);
                    phase = 0;              // Count 0 of a new period
                    phase_valid = 1'b1;
                end
                low_run++;
            end else begin
                if (!prev_be && seen_be) begin
                    periods++;
                    if (low_run != 16) report_mismatch("cpu_be_low_clocks", 16, low_run);
                end
                seen_be = 1'b1;
                low_run = 0;
            end
            if (cpu_clock_o && !prev_clock && phase_valid && phase != 32)
                report_mismatch("phi2_delay", 32, phase);
            if (wb_ack_o) acks++;
            phase++;
            prev_be    = cpu_be_o;
            prev_clock = cpu_clock_o;
        end
    end

    always @(posedge sys_clock) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: table not finished after %0d cycles", cycles);
            $display("Entries: %0d, periods: %0d, errors: %0d", entries.size(), periods, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // One Wishbone request, held while stalled, ended by the ack
    task automatic wb_transfer(input string name, input logic [17:0] addr, input logic we,
                               input logic [7:0] wdata, output logic [7:0] rdata,
                               output bit acked);
        int waited;
        bit accepted;
        waited   = 0;
        accepted = 1'b0;
        acked    = 1'b0;
        rdata    = '0;
        requests++;
        @(posedge sys_clock);
        #1;
        wb_addr   = addr;
        wb_we     = we;
        wb_wdata  = wdata;
        wb_cycle  = 1'b1;
        wb_strobe = 1'b1;
        while (!acked && waited < 2 * TIMING_PERIOD) begin
            @(negedge sys_clock);
            if (wb_ack_o) begin
                acked = 1'b1;
                rdata = wb_data_o;
            end
            if (!addr[17] && !cpu_be_o && (ram_oe_o || ram_we_o) && sram_addr !== addr[16:0])
                report_mismatch({name, "_ram_addr"}, addr[16:0], sram_addr);
            if (!addr[17] && !cpu_be_o && (ram_oe_o || ram_we_o) &&
                {ram_addr_a15_o, ram_addr_a11_o, ram_addr_a10_o} !==
                {addr[15], addr[11], addr[10]})
                report_mismatch({name, "_ram_pins"}, {addr[15], addr[11], addr[10]},
                                {ram_addr_a15_o, ram_addr_a11_o, ram_addr_a10_o});
            if (wb_strobe && !wb_stall_o) accepted = 1'b1;
            @(posedge sys_clock);
            #1;
            if (accepted) wb_strobe = 1'b0;
            waited++;
        end
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        wb_we     = 1'b0;
    endtask

    // CPU access placed at count 40
    task automatic apply_cpu(input entry_t e);
        logic [7:0] got;
        @(posedge cpu_clock_o);
        repeat (8) @(posedge sys_clock);
        #1;
        cpu_addr = e.addr[15:0];
        cpu_we   = e.we;
        cpu_data = e.data;
        @(negedge sys_clock);
        got = {ram_oe_o, ram_we_o, io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o,
               ram_addr_a11_o, ram_addr_a10_o};
        if (got !== e.expected) report_mismatch(e.name, e.expected, got);
        if ({ram_addr_a16_o, ram_addr_a15_o} !== {1'b0, e.addr[15]})
            report_mismatch({e.name, "_a16_a15"}, {1'b0, e.addr[15]},
                            {ram_addr_a16_o, ram_addr_a15_o});
        // Address and direction stay on the bus into the next host window
    endtask

    task automatic apply_reg(input entry_t e);
        logic [7:0] rdata;
        bit         acked;
        wb_transfer(e.name, e.addr, e.we, e.data, rdata, acked);
        if (!acked) begin
            report_failure({e.name, ": register request got no ack"});
        end else if (!e.we && rdata !== e.expected) begin
            report_mismatch(e.name, e.expected, rdata);
        end
    endtask

    // Write then read back at a random address
    task automatic apply_ram(input entry_t e);
        logic [16:0] addr;
        logic [7:0]  data;
        logic [7:0]  rdata;
        bit          acked;
        addr = {e.addr[16], 16'($urandom)};
        data = 8'($urandom);
        wb_transfer(e.name, {1'b0, addr}, 1'b1, data, rdata, acked);
        if (!acked) report_failure({e.name, ": SRAM write got no ack"});
        wb_transfer(e.name, {1'b0, addr}, 1'b0, 8'h00, rdata, acked);
        if (!acked) begin
            report_failure({e.name, ": SRAM read got no ack"});
        end else if (rdata !== data) begin
            report_mismatch(e.name, data, rdata);
        end
    endtask

    initial begin
        void'($urandom(32'h4f22_38fe));
        sys_reset_n = 1'b0;
        wb_addr     = '0;
        wb_wdata    = '0;
        wb_we       = 1'b0;
        wb_cycle    = 1'b0;
        wb_strobe   = 1'b0;
        cpu_addr    = '0;
        cpu_data    = '0;
        cpu_we      = 1'b0;
        prev_be     = 1'b0;
        prev_clock  = 1'b0;
        load_table();
        cycle_limit = (2 * entries.size() + 8) * TIMING_PERIOD;
        repeat (2) @(posedge sys_clock);
        #1;
        sys_reset_n = 1'b1;

        @(negedge sys_clock);
        if ({cpu_reset_o, cpu_ready_o, ram_oe_o, ram_we_o, wb_ack_o} !== 5'b10000)
            report_mismatch("reset_state", 5'b10000,
                            {cpu_reset_o, cpu_ready_o, ram_oe_o, ram_we_o, wb_ack_o});

        foreach (entries[i]) begin
            case (entries[i].kind)
                ACC_CPU: apply_cpu(entries[i]);
                ACC_REG: apply_reg(entries[i]);
                default: apply_ram(entries[i]);
            endcase
        end

        repeat (4) @(negedge sys_clock);
        if ({cpu_ready_o, cpu_reset_o} !== 2'b10)
            report_mismatch("cpu_released", 2'b10, {cpu_ready_o, cpu_reset_o});
        if (acks != requests) report_mismatch("ack_count", requests, acks);
        if (periods < 4) report_failure("too few bus periods seen to check the timing");

        $display("Entries: %0d, periods: %0d, errors: %0d", entries.size(), periods, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
